// File: files.f
sdram_pkg.sv
sdram_cmd_if.sv
sdram_timer_if.sv
sdram_timer.sv
sdram_sequencer.sv
sdram_datapath.sv
sdram_ctrl_top.sv
sdram_model.sv
sdram_ctrl_assert.sv
tb_sdram.sv

// File: Makefile
.PHONY: all lint clean

all: obj_dir/Vtb_sdram
	out=$$(./obj_dir/Vtb_sdram); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

obj_dir/Vtb_sdram: files.f *.sv
	verilator --binary --timing --assert --top-module tb_sdram -f files.f

lint:
	verilator --lint-only --timing --assert --top-module tb_sdram -f files.f

clean:
	rm -rf obj_dir

// File: tb_sdram.sv
module tb_sdram import sdram_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 400;

    logic clk;
    logic nreset;
    logic [CPU_ADDRESS_WIDTH-1:0] cpu_address;
    logic [31:0] cpu_data_in;
    logic [31:0] cpu_data_out;
    logic cpu_req;
    logic [3:0] cpu_nwr;
    logic cpu_ack;
    logic sdram_clk;
    logic [SDRAM_ADDRESS_WIDTH-1:0] sdram_address;
    logic [BANK_BITS-1:0] sdram_ba;
    logic sdram_ncs;
    logic sdram_ras;
    logic sdram_cas;
    logic sdram_nwe;
    logic sdram_data_noe;
    logic [15:0] sdram_data_in;
    logic [15:0] sdram_data_out;
    logic [1:0] sdram_dqm;
    logic model_fault;
    int refresh_count;

    logic [31:0] shadow [logic [CPU_ADDRESS_WIDTH-1:0]];
    logic [31:0] exp_data;
    logic exp_is_read;
    logic ack_prev;
    int activate_count;
    integer seed;

    sdram_ctrl_top sdram_ctrl_top_i (.*);

    sdram_model model_i (
        .sdram_clk(sdram_clk),
        .sdram_address(sdram_address),
        .sdram_ba(sdram_ba),
        .sdram_ncs(sdram_ncs),
        .sdram_ras(sdram_ras),
        .sdram_cas(sdram_cas),
        .sdram_nwe(sdram_nwe),
        .sdram_data_out(sdram_data_out),
        .sdram_dqm(sdram_dqm),
        .sdram_data_in(sdram_data_in),
        .fault(model_fault),
        .refresh_count(refresh_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] expected_read(input logic [CPU_ADDRESS_WIDTH-1:0] a);
        return shadow.exists(a) ? shadow[a] : 32'h0;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] nwr);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (!nwr[i]) result[8*i +: 8] = new_word[8*i +: 8];
        end
        return result;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    endtask

    // Counts activates and compares read data at each rising acknowledge.
    always @(negedge clk) begin
        if ({sdram_ncs, sdram_ras, sdram_cas, sdram_nwe} == 4'b0011) begin
            activate_count <= activate_count + 1;
        end
        if (cpu_ack && !ack_prev && exp_is_read) begin
            check_value(cpu_data_out, exp_data, "read data");
        end
        ack_prev <= cpu_ack;
    end

    always @(posedge model_fault) begin
        $display("CHECKS FAILED");
        $fatal(1, "SDRAM model fault");
    end

    task automatic run_access(input logic [CPU_ADDRESS_WIDTH-1:0] addr,
                              input logic [31:0] data, input logic [3:0] nwr, input int hold);
        int n;
        int actives_before;
        @(negedge clk);
        exp_is_read = &nwr;
        exp_data = expected_read(addr);
        actives_before = activate_count;
        cpu_address = addr;
        cpu_data_in = data;
        cpu_nwr = nwr;
        cpu_req = 1'b1;
        n = 0;
        while (!cpu_ack) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("no acknowledge for a request");
        end
        if (!(&nwr)) shadow[addr] = merge_bytes(expected_read(addr), data, nwr);
        // A held request must keep the acknowledge and not be served again.
        repeat (hold) begin
            @(negedge clk);
            check_value(32'(cpu_ack), 32'd1, "acknowledge while request held");
        end
        cpu_req = 1'b0;
        n = 0;
        while (cpu_ack) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYCLES) report_timeout("acknowledge did not fall");
        end
        check_value(activate_count, actives_before + 1, "activates per request");
    endtask

    initial begin
        logic [CPU_ADDRESS_WIDTH-1:0] base;
        logic [CPU_ADDRESS_WIDTH-1:0] a;
        logic [3:0] nwr;
        seed = 79116;
        nreset = 1'b0;
        cpu_address = '0;
        cpu_data_in = '0;
        cpu_req = 1'b0;
        cpu_nwr = 4'hf;
        exp_is_read = 1'b0;
        exp_data = '0;
        ack_prev = 1'b0;
        activate_count = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        nreset = 1'b1;

        base = 23'h12_3456;
        run_access(base, 32'hcafe_f00d, 4'h0, 0);
        run_access(base, 32'h0, 4'hf, 0);
        run_access(base, 32'h1122_3344, 4'b0101, 0);
        run_access(base, 32'h5566_7788, 4'b1110, 0);
        run_access(base, 32'h0, 4'hf, 0);
        run_access(base, 32'h0, 4'hf, 5);

        // Bank, row and column neighbours.
        run_access(base ^ 23'h20_0000, 32'haaaa_0001, 4'h0, 0);
        run_access(base ^ 23'h00_0100, 32'hbbbb_0002, 4'h0, 0);
        run_access(base ^ 23'h00_0001, 32'hcccc_0003, 4'h0, 0);
        run_access(base, 32'h0, 4'hf, 0);
        run_access(base ^ 23'h20_0000, 32'h0, 4'hf, 0);
        run_access(base ^ 23'h00_0100, 32'h0, 4'hf, 0);
        run_access(base ^ 23'h00_0001, 32'h0, 4'hf, 2);

        for (int i = 0; i < 60; i++) begin
            a = CPU_ADDRESS_WIDTH'($random(seed)) & 23'h60_0307;
            nwr = 4'($random(seed));
            if ($random(seed) & 1) nwr = 4'hf;
            run_access(a, $random(seed), nwr, {$random(seed)} % 3);
        end

        if (refresh_count == 0) begin
            $display("No refresh was seen during traffic");
            $display("CHECKS FAILED");
            $fatal(1, "no refresh");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    initial begin
        #2000000;
        report_timeout("simulation time limit reached");
    end

endmodule

// File: sdram_ctrl_assert.sv
module sdram_ctrl_assert import sdram_pkg::*; (
    input logic clk,
    input logic nreset,
    input logic sdram_ncs,
    input logic sdram_ras,
    input logic sdram_cas,
    input logic sdram_nwe,
    input logic sdram_data_noe,
    input logic cpu_req,
    input logic cpu_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    logic is_write;
    logic is_refresh;
    logic is_active;
    logic [AUTOREFRESH_LATENCY-1:0] recent_refresh;

    assign is_write = {sdram_ncs, sdram_ras, sdram_cas, sdram_nwe} == 4'b0100;
    assign is_refresh = {sdram_ncs, sdram_ras, sdram_cas, sdram_nwe} == 4'b0001;
    assign is_active = {sdram_ncs, sdram_ras, sdram_cas, sdram_nwe} == 4'b0011;

    // Refreshes seen in the last AUTOREFRESH_LATENCY cycles.
    always_ff @(posedge clk) begin
        recent_refresh <= {recent_refresh[AUTOREFRESH_LATENCY-2:0], is_refresh};
    end

    // Bus is driven on the WRITE beat and the beat after it.
    noe_write_only: assert property (@(posedge clk) disable iff (!nreset)
        !sdram_data_noe == (is_write || $past(is_write)))
        else $error("data bus not driven exactly on the write beats");

    ack_needs_req: assert property (@(posedge clk) disable iff (!nreset)
        $rose(cpu_ack) |-> $past(cpu_req))
        else $error("acknowledge without request");

    refresh_gap: assert property (@(posedge clk) disable iff (!nreset)
        is_active |-> recent_refresh == '0)
        else $error("activate too soon after refresh");

endmodule

bind sdram_ctrl_top sdram_ctrl_assert sdram_ctrl_assert_i (.*);

// File: sdram_model.sv
module sdram_model import sdram_pkg::*; (
    input logic sdram_clk,
    input logic [SDRAM_ADDRESS_WIDTH-1:0] sdram_address,
    input logic [BANK_BITS-1:0] sdram_ba,
    input logic sdram_ncs,
    input logic sdram_ras,
    input logic sdram_cas,
    input logic sdram_nwe,
    input logic [15:0] sdram_data_out,
    input logic [1:0] sdram_dqm,
    output logic [15:0] sdram_data_in,
    output logic fault,
    output int refresh_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] mem [int];
    logic [SDRAM_ADDRESS_WIDTH-1:0] open_row [4];
    int init_step;
    int read_phase;
    int write_phase;
    int burst_addr;

    initial begin
        fault = 1'b0;
        refresh_count = 0;
        init_step = 0;
        read_phase = 0;
        write_phase = 0;
        burst_addr = 0;
        sdram_data_in = '0;
    end

    function automatic logic [15:0] read_word(input int a);
        return mem.exists(a) ? mem[a] : 16'h0000;
    endfunction

    task automatic raise_fault(input string msg);
        $display("SDRAM model error at %0t: %s", $time, msg);
        fault = 1'b1;
    endtask

    always @(posedge sdram_clk) begin
        logic [3:0] pins;
        pins = {sdram_ncs, sdram_ras, sdram_cas, sdram_nwe};
        // Burst 2 with CAS latency 2.
        if (read_phase == 2) begin
            sdram_data_in <= read_word(burst_addr);
        end else if (read_phase == 3) begin
            sdram_data_in <= read_word(burst_addr | 1);
        end
        read_phase = (read_phase == 3 || read_phase == 0) ? 0 : read_phase + 1;
        if (write_phase == 1) begin
            // Second write beat with DQM masking.
            mem[burst_addr | 1] = read_word(burst_addr | 1);
            if (!sdram_dqm[0]) mem[burst_addr | 1][7:0] = sdram_data_out[7:0];
            if (!sdram_dqm[1]) mem[burst_addr | 1][15:8] = sdram_data_out[15:8];
            write_phase = 0;
        end
        case (pins)
            4'b0010: begin
                if (init_step == 0 && sdram_address[10]) init_step = 1;
                else if (init_step < 4) raise_fault("precharge-all out of init order");
            end
            4'b0001: begin
                if (init_step == 1 || init_step == 2) init_step = init_step + 1;
                else if (init_step == 4) refresh_count = refresh_count + 1;
                else raise_fault("refresh out of init order");
            end
            4'b0000: begin
                if (init_step != 3) raise_fault("mode load out of init order");
                else if (sdram_address != 13'h021) raise_fault("wrong mode register value");
                init_step = 4;
            end
            4'b0011: begin
                if (init_step != 4) raise_fault("activate before mode load");
                open_row[sdram_ba] = sdram_address;
            end
            4'b0101, 4'b0100: begin
                if (init_step != 4) raise_fault("column command before mode load");
                burst_addr = int'({sdram_ba, open_row[sdram_ba], sdram_address[8:0]});
                if (pins == 4'b0101) begin
                    read_phase = 1;
                end else begin
                    mem[burst_addr] = read_word(burst_addr);
                    if (!sdram_dqm[0]) mem[burst_addr][7:0] = sdram_data_out[7:0];
                    if (!sdram_dqm[1]) mem[burst_addr][15:8] = sdram_data_out[15:8];
                    write_phase = 1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: sdram_ctrl_top.sv
module sdram_ctrl_top import sdram_pkg::*; (
    input logic clk,
    input logic nreset,
    input logic [CPU_ADDRESS_WIDTH-1:0] cpu_address,
    input logic [31:0] cpu_data_in,
    output logic [31:0] cpu_data_out,
    input logic cpu_req,
    input logic [3:0] cpu_nwr,
    output logic cpu_ack,
    output logic sdram_clk,
    output logic [SDRAM_ADDRESS_WIDTH-1:0] sdram_address,
    output logic [BANK_BITS-1:0] sdram_ba,
    output logic sdram_ncs,
    output logic sdram_ras,
    output logic sdram_cas,
    output logic sdram_nwe,
    output logic sdram_data_noe,
    input logic [15:0] sdram_data_in,
    output logic [15:0] sdram_data_out,
    output logic [1:0] sdram_dqm
);

    sdram_cmd_if cmd_if_i ();
    sdram_timer_if timer_if_i ();

    // The device samples pins mid-cycle on the opposite edge.
    assign sdram_clk = ~clk;

    sdram_timer timer_i (
        .clk(clk),
        .nreset(nreset),
        .tmr(timer_if_i.timer)
    );

    sdram_sequencer sequencer_i (
        .clk(clk),
        .nreset(nreset),
        .cpu_req(cpu_req),
        .cpu_nwr(cpu_nwr),
        .cpu_ack(cpu_ack),
        .cmd(cmd_if_i.sequencer),
        .tmr(timer_if_i.sequencer)
    );

    sdram_datapath datapath_i (
        .clk(clk),
        .nreset(nreset),
        .cmd(cmd_if_i.datapath),
        .cpu_address(cpu_address),
        .cpu_data_in(cpu_data_in),
        .cpu_nwr(cpu_nwr),
        .cpu_data_out(cpu_data_out),
        .sdram_address(sdram_address),
        .sdram_ba(sdram_ba),
        .sdram_ncs(sdram_ncs),
        .sdram_ras(sdram_ras),
        .sdram_cas(sdram_cas),
        .sdram_nwe(sdram_nwe),
        .sdram_data_noe(sdram_data_noe),
        .sdram_data_in(sdram_data_in),
        .sdram_data_out(sdram_data_out),
        .sdram_dqm(sdram_dqm)
    );

endmodule

// File: sdram_datapath.sv
module sdram_datapath import sdram_pkg::*; (
    input logic clk,
    input logic nreset,
    sdram_cmd_if.datapath cmd,
    input logic [CPU_ADDRESS_WIDTH-1:0] cpu_address,
    input logic [31:0] cpu_data_in,
    input logic [3:0] cpu_nwr,
    output logic [31:0] cpu_data_out,
    output logic [SDRAM_ADDRESS_WIDTH-1:0] sdram_address,
    output logic [BANK_BITS-1:0] sdram_ba,
    output logic sdram_ncs,
    output logic sdram_ras,
    output logic sdram_cas,
    output logic sdram_nwe,
    output logic sdram_data_noe,
    input logic [15:0] sdram_data_in,
    output logic [15:0] sdram_data_out,
    output logic [1:0] sdram_dqm
);

    logic [3:0] cmd_pins;
    logic [SDRAM_ADDRESS_WIDTH-1:0] address_next;
    logic write_beat;
    logic [15:0] data_low;
    logic [15:0] data_high;

    assign write_beat = (cmd.cmd == CMD_WRITE) || cmd.beat_high;
    assign cpu_data_out = {data_high, data_low};

    // Pin order is ncs, ras, cas, nwe.
    always_comb begin
        case (cmd.cmd)
            CMD_ACTIVE: cmd_pins = 4'b0011;
            CMD_READ: cmd_pins = 4'b0101;
            CMD_WRITE: cmd_pins = 4'b0100;
            CMD_REFRESH: cmd_pins = 4'b0001;
            CMD_PRECHARGE_ALL: cmd_pins = 4'b0010;
            CMD_LOAD_MODE: cmd_pins = 4'b0000;
            default: cmd_pins = 4'b0111;
        endcase
    end

    always_comb begin
        address_next = '0;
        case (cmd.addr_sel)
            ADDR_ROW: begin
                address_next = cpu_address[SDRAM_ADDRESS_WIDTH+SDRAM_COLUMN_WIDTH-2:
                                           SDRAM_COLUMN_WIDTH-1];
            end
            ADDR_COLUMN: begin
                // Low half-word first, so column bit 0 is zero.
                address_next[SDRAM_COLUMN_WIDTH-1:0] = {cpu_address[SDRAM_COLUMN_WIDTH-2:0], 1'b0};
                address_next[AUTO_PRECHARGE_BIT] = 1'b1;
            end
            ADDR_MODE: address_next = MODE_REGISTER_VALUE;
            default: address_next[AUTO_PRECHARGE_BIT] = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            {sdram_ncs, sdram_ras, sdram_cas, sdram_nwe} <= 4'b0111;
            sdram_data_noe <= 1'b1;
        end else begin
            {sdram_ncs, sdram_ras, sdram_cas, sdram_nwe} <= cmd_pins;
            sdram_data_noe <= !write_beat;
        end
    end

    always_ff @(posedge clk) begin
        sdram_address <= address_next;
        sdram_ba <= cpu_address[CPU_ADDRESS_WIDTH-1 -: BANK_BITS];
        sdram_data_out <= cmd.beat_high ? cpu_data_in[31:16] : cpu_data_in[15:0];
        // Reads are never masked.
        if (write_beat) begin
            sdram_dqm <= cmd.beat_high ? cpu_nwr[3:2] : cpu_nwr[1:0];
        end else begin
            sdram_dqm <= 2'b00;
        end
        if (cmd.capture_low) begin
            data_low <= sdram_data_in;
        end
        if (cmd.capture_high) begin
            data_high <= sdram_data_in;
        end
    end

endmodule

// File: sdram_sequencer.sv
module sdram_sequencer import sdram_pkg::*; (
    input logic clk,
    input logic nreset,
    input logic cpu_req,
    input logic [3:0] cpu_nwr,
    output logic cpu_ack,
    sdram_cmd_if.sequencer cmd,
    sdram_timer_if.sequencer tmr
);

    sdram_state_e state;
    sdram_state_e next_state;
    logic [1:0] init_count;
    logic is_read;
    logic req;

    assign is_read = &cpu_nwr;
    // Only a request whose acknowledge has dropped is a new one.
    assign req = cpu_req && !cpu_ack;

    always_comb begin
        cmd.cmd = CMD_NOP;
        cmd.addr_sel = ADDR_ROW;
        cmd.beat_high = 1'b0;
        cmd.capture_low = 1'b0;
        cmd.capture_high = 1'b0;
        tmr.wait_load = 1'b0;
        tmr.wait_value = '0;
        tmr.refresh_ack = 1'b0;
        case (state)
            ST_INIT: begin
                // Count 3 precharges, 2 and 1 refresh, 0 loads the mode.
                case (init_count)
                    2'd3: begin
                        cmd.cmd = CMD_PRECHARGE_ALL;
                        cmd.addr_sel = ADDR_PRECHARGE_ALL;
                    end
                    2'd0: begin
                        cmd.cmd = CMD_LOAD_MODE;
                        cmd.addr_sel = ADDR_MODE;
                    end
                    default: cmd.cmd = CMD_REFRESH;
                endcase
                tmr.wait_load = 1'b1;
                tmr.wait_value = WAIT_COUNTER_BITS'(AUTOREFRESH_LATENCY - 1);
            end
            ST_IDLE: begin
                if (tmr.refresh_req) begin
                    cmd.cmd = CMD_REFRESH;
                    tmr.refresh_ack = 1'b1;
                    tmr.wait_load = 1'b1;
                    tmr.wait_value = WAIT_COUNTER_BITS'(AUTOREFRESH_LATENCY - 1);
                end else if (req) begin
                    cmd.cmd = CMD_ACTIVE;
                    tmr.wait_load = 1'b1;
                    tmr.wait_value = WAIT_COUNTER_BITS'(BANK_ACTIVATE_LATENCY - 1);
                end
            end
            ST_CAS: begin
                cmd.cmd = is_read ? CMD_READ : CMD_WRITE;
                cmd.addr_sel = ADDR_COLUMN;
                if (is_read) begin
                    tmr.wait_load = 1'b1;
                    tmr.wait_value = WAIT_COUNTER_BITS'(CAS_LATENCY - 1);
                end
            end
            ST_READ: begin
                cmd.capture_low = 1'b1;
            end
            ST_READ2: begin
                // Second read beat, or second write beat.
                cmd.capture_high = is_read;
                cmd.beat_high = !is_read;
                tmr.wait_load = 1'b1;
                tmr.wait_value = WAIT_COUNTER_BITS'(PRECHARGE_LATENCY - 1);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= ST_INIT;
            next_state <= ST_IDLE;
            init_count <= 2'd3;
            cpu_ack <= 1'b0;
        end else begin
            case (state)
                ST_INIT: begin
                    init_count <= init_count - 2'd1;
                    next_state <= (init_count == 2'd0) ? ST_IDLE : ST_INIT;
                    state <= ST_WAIT;
                end
                ST_IDLE: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                    end
                    if (tmr.refresh_req) begin
                        next_state <= ST_IDLE;
                        state <= ST_WAIT;
                    end else if (req) begin
                        next_state <= ST_CAS;
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (tmr.wait_done) begin
                        state <= next_state;
                    end
                end
                ST_CAS: begin
                    next_state <= ST_READ;
                    state <= is_read ? ST_WAIT : ST_READ2;
                end
                ST_READ: begin
                    state <= ST_READ2;
                end
                ST_READ2: begin
                    cpu_ack <= 1'b1;
                    next_state <= ST_IDLE;
                    state <= ST_WAIT;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: sdram_timer.sv
module sdram_timer import sdram_pkg::*; (
    input logic clk,
    input logic nreset,
    sdram_timer_if.timer tmr
);

    logic [WAIT_COUNTER_BITS-1:0] wait_count;
    logic [REFRESH_COUNTER_BITS-1:0] refresh_count;
    logic refresh_pending;

    assign tmr.wait_done = wait_count == '0;
    assign tmr.refresh_req = refresh_pending;

    // Wait counter stops at zero until the next load.
    always_ff @(posedge clk) begin
        if (!nreset) begin
            wait_count <= '0;
        end else if (tmr.wait_load) begin
            wait_count <= tmr.wait_value;
        end else if (wait_count != '0) begin
            wait_count <= wait_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            refresh_count <= '0;
            refresh_pending <= 1'b0;
        end else begin
            refresh_count <= refresh_count + 1'b1;
            if (tmr.refresh_ack) begin
                refresh_pending <= 1'b0;
            end
            // A wrap in the same cycle as an acknowledge starts a new request.
            if (refresh_count == '1) begin
                refresh_pending <= 1'b1;
            end
        end
    end

endmodule

// File: sdram_timer_if.sv
interface sdram_timer_if import sdram_pkg::*; ();

    logic wait_load;
    logic [WAIT_COUNTER_BITS-1:0] wait_value;
    logic wait_done;
    logic refresh_req;
    logic refresh_ack;

    modport sequencer (
        output wait_load,
        output wait_value,
        output refresh_ack,
        input wait_done,
        input refresh_req
    );

    modport timer (
        input wait_load,
        input wait_value,
        input refresh_ack,
        output wait_done,
        output refresh_req
    );

endinterface

// File: sdram_cmd_if.sv
interface sdram_cmd_if import sdram_pkg::*; ();

    sdram_cmd_e cmd;
    sdram_addr_sel_e addr_sel;
    // Second write beat, high half-word and upper byte enables.
    logic beat_high;
    logic capture_low;
    logic capture_high;

    modport sequencer (
        output cmd,
        output addr_sel,
        output beat_high,
        output capture_low,
        output capture_high
    );

    modport datapath (
        input cmd,
        input addr_sel,
        input beat_high,
        input capture_low,
        input capture_high
    );

endinterface

// File: sdram_pkg.sv
package sdram_pkg;

    // Device geometry.
    localparam int SDRAM_ADDRESS_WIDTH = 13;
    localparam int SDRAM_COLUMN_WIDTH = 9;
    localparam int BANK_BITS = 2;

    // Word address, one column bit is taken by the half-word beat.
    localparam int CPU_ADDRESS_WIDTH = BANK_BITS + SDRAM_ADDRESS_WIDTH + SDRAM_COLUMN_WIDTH - 1;

    // A10 selects auto-precharge on column commands and all banks on precharge.
    localparam int AUTO_PRECHARGE_BIT = 10;

    // Burst length 2, sequential burst, CAS latency 2.
    localparam logic [SDRAM_ADDRESS_WIDTH-1:0] MODE_REGISTER_VALUE = 13'h021;

    localparam int AUTOREFRESH_LATENCY = 3;
    localparam int BANK_ACTIVATE_LATENCY = 2;
    localparam int CAS_LATENCY = 2;
    localparam int PRECHARGE_LATENCY = 2;

    localparam int WAIT_COUNTER_BITS = 3;
    // 256 cycles between refresh requests at 25 MHz.
    localparam int REFRESH_COUNTER_BITS = 8;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_WAIT,
        ST_CAS,
        ST_READ,
        ST_READ2
    } sdram_state_e;

    typedef enum logic [2:0] {
        CMD_NOP,
        CMD_ACTIVE,
        CMD_READ,
        CMD_WRITE,
        CMD_REFRESH,
        CMD_PRECHARGE_ALL,
        CMD_LOAD_MODE
    } sdram_cmd_e;

    typedef enum logic [1:0] {
        ADDR_ROW,
        ADDR_COLUMN,
        ADDR_MODE,
        ADDR_PRECHARGE_ALL
    } sdram_addr_sel_e;

endpackage
